//--- ppu_pkg.sv
// Config word and PAL flag are expected to be synchronous to VCLK_Tx already; enum codes fixed
package ppu_pkg;

  // ====================================================================
  // Output resolution classes and resolved video modes
  // ====================================================================

  // Requested output resolution as set in the config word
  typedef enum logic [2:0] {
    TGT_480P  = 3'd0,   // 480p or 576p depending on rate
    TGT_720P  = 3'd1,
    TGT_960P  = 3'd2,
    TGT_1080P = 3'd3,
    TGT_1200P = 3'd4
  } target_res_t;

  // Resolved output timing
  // Bit 3 marks the 50 Hz family, lower bits follow the resolution
  typedef enum logic [3:0] {
    VM_480P60  = 4'h0,  // Reset default
    VM_VGA60   = 4'h1,  // 640x480 variant of 480p
    VM_720P60  = 4'h2,
    VM_960P60  = 4'h3,
    VM_1080P60 = 4'h4,
    VM_1200P60 = 4'h5,
    VM_576P50  = 4'h8,
    VM_720P50  = 4'hA,
    VM_960P50  = 4'hB,
    VM_1080P50 = 4'hC,
    VM_1200P50 = 4'hD
  } vmode_t;

  // ====================================================================
  // Config word and sync bundle
  // ====================================================================

  typedef struct packed {
    target_res_t target_res;
    logic        use_vga_480p;  // VGA timing instead of 480p at 60 Hz
    logic        force50;
    logic        force60;       // Takes priority over force50
    logic        llm;           // Low latency mode, blocks forced rates
    logic        limited_rgb;   // Limited range output when set
    logic [4:0]  vscale;        // Vertical scale factor code
  } ppu_cfg_t;                  // 13 bits total

  typedef struct packed {
    logic vsync;
    logic hsync;
    logic de;
  } vid_sync_t;

  // Range conversion constants, given at 8 bits per colour
  localparam logic [7:0] LIMIT_COEFF  = 8'd220;  // 235 - 16 + 1 code span
  localparam logic [7:0] LIMIT_OFFSET = 8'd16;   // Black level

  // Scanline thickness class thresholds on the vscale code
  localparam logic [4:0] SL_THICK_MID  = 5'd6;   // Below 3.5x stays thin
  localparam logic [4:0] SL_THICK_HIGH = 5'd14;  // From 5.5x on thickest

endpackage

//--- vmode_resolver.sv
// Decode is registered, so outputs follow a config or PAL change one VCLK_Tx cycle later
`timescale 1ns/1ps

module vmode_resolver
  import ppu_pkg::*;
(
  input  logic       VCLK_Tx,
  input  logic       nVRST_Tx,
  input  ppu_cfg_t   cfg_i,
  input  logic       palmode_i,       // PAL source detected
  output vmode_t     videomode_o,
  output logic [1:0] sl_thickness_o,  // 0 thin, 1 mid, 2 thick
  output logic       limited_en_o
);

  vmode_t     mode60_w;   // Candidate at 60 Hz
  vmode_t     mode50_w;   // Candidate at 50 Hz
  logic       use50_w;
  vmode_t     mode_w;
  logic [1:0] thick_w;

  // ====================================================================
  // Mode candidates per target
  // ====================================================================

  always_comb begin
    case (cfg_i.target_res)
      TGT_720P: begin
        mode60_w = VM_720P60;
        mode50_w = VM_720P50;
      end
      TGT_960P: begin
        mode60_w = VM_960P60;
        mode50_w = VM_960P50;
      end
      TGT_1080P: begin
        mode60_w = VM_1080P60;
        mode50_w = VM_1080P50;
      end
      TGT_1200P: begin
        mode60_w = VM_1200P60;
        mode50_w = VM_1200P50;
      end
      default: begin  // TGT_480P and unused codes
        mode60_w = cfg_i.use_vga_480p ? VM_VGA60 : VM_480P60;
        mode50_w = VM_576P50;
      end
    endcase
  end

  // Forced rates only count outside low latency mode
  always_comb begin
    if (cfg_i.force60 && !cfg_i.llm)
      use50_w = 1'b0;
    else if (cfg_i.force50 && !cfg_i.llm)
      use50_w = 1'b1;
    else
      use50_w = palmode_i;  // Follow the source
  end

  assign mode_w = use50_w ? mode50_w : mode60_w;

  always_comb begin
    if (cfg_i.vscale < SL_THICK_MID)
      thick_w = 2'd0;
    else if (cfg_i.vscale < SL_THICK_HIGH)
      thick_w = 2'd1;
    else
      thick_w = 2'd2;
  end

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      videomode_o    <= VM_480P60;
      sl_thickness_o <= 2'd0;
      limited_en_o   <= 1'b0;
    end else begin
      videomode_o    <= mode_w;
      sl_thickness_o <= thick_w;
      limited_en_o   <= cfg_i.limited_rgb;
    end
  end

  // Only three thickness classes exist downstream
  a_thick_class: assert property (
    @(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    sl_thickness_o != 2'd3
  );

endmodule

//--- rgb_range_lane.sv
// Limited scaling needs COLOR_W of 8 or more; range select is sampled at the last stage only
`timescale 1ns/1ps

module rgb_range_lane
  import ppu_pkg::*;
#(
  parameter int COLOR_W = 8
) (
  input  logic               VCLK_Tx,
  input  logic               nVRST_Tx,
  input  logic               limited_en_i,
  input  logic [COLOR_W-1:0] color_i,
  output logic [COLOR_W-1:0] color_o   // Three cycles after color_i
);

  // Offset and upper limit scaled to lane width
  localparam logic [COLOR_W-1:0] OFFS_W = COLOR_W'(LIMIT_OFFSET) << (COLOR_W - 8);
  localparam logic [COLOR_W-1:0] LIM_HI = COLOR_W'(LIMIT_OFFSET + LIMIT_COEFF) << (COLOR_W - 8);

  logic [COLOR_W+7:0] prod_w;     // Full product v * 220
  logic [COLOR_W:0]   scaled_q;   // Scaled value plus half bit
  logic [COLOR_W-1:0] rounded_q;
  logic [COLOR_W-1:0] full_q1;    // Full range copy, stage one
  logic [COLOR_W-1:0] full_q2;    // Full range copy, stage two
  logic [COLOR_W-1:0] limited_w;

  assign prod_w    = color_i * LIMIT_COEFF;
  assign limited_w = rounded_q + OFFS_W;  // Upper nibble +1 at 8 bits

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      scaled_q  <= '0;
      rounded_q <= '0;
      full_q1   <= '0;
      full_q2   <= '0;
      color_o   <= '0;
    end else begin
      // Keep top COLOR_W+1 bits of the product
      scaled_q  <= prod_w[COLOR_W+7:7];
      full_q1   <= color_i;
      // Round up by the dropped half bit
      rounded_q <= scaled_q[COLOR_W:1] + COLOR_W'(scaled_q[0]);
      full_q2   <= full_q1;
      // Range select
      if (limited_en_i)
        color_o <= limited_w;
      else
        color_o <= full_q2;
    end
  end

  // Whole input span lands inside the limited window
  a_limited_window: assert property (
    @(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    (limited_w >= OFFS_W) && (limited_w <= LIM_HI)
  );

endmodule

//--- video_out_stage.sv
// Sync delay of three cycles matches rgb_range_lane; source must blank pixels outside DE
`timescale 1ns/1ps

module video_out_stage
  import ppu_pkg::*;
#(
  parameter int COLOR_W = 8
) (
  input  logic                 VCLK_Tx,
  input  logic                 nVRST_Tx,
  input  vid_sync_t            sync_i,
  input  logic [3*COLOR_W-1:0] lane_color_i,  // Lane 0 red in the low slice
  output logic                 VSYNC_o,
  output logic                 HSYNC_o,
  output logic                 DE_o,
  output logic [3*COLOR_W-1:0] VD_o           // Red, green, blue from the top
);

  // Black level of one channel after limited range conversion
  localparam logic [COLOR_W-1:0] BLACK_LIM = COLOR_W'(LIMIT_OFFSET) << (COLOR_W - 8);

  vid_sync_t sync_d1;
  vid_sync_t sync_d2;
  vid_sync_t sync_q;   // Aligned with lane outputs

  // ====================================================================
  // Sync delay line
  // ====================================================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      sync_d1 <= '0;
      sync_d2 <= '0;
      sync_q  <= '0;
    end else begin
      sync_d1 <= sync_i;
      sync_d2 <= sync_d1;
      sync_q  <= sync_d2;
    end
  end

  assign VSYNC_o = sync_q.vsync;
  assign HSYNC_o = sync_q.hsync;
  assign DE_o    = sync_q.de;

  // Lane order reversed so red sits at the top of VD_o
  assign VD_o = {
    lane_color_i[0         +: COLOR_W],   // Red
    lane_color_i[COLOR_W   +: COLOR_W],   // Green
    lane_color_i[2*COLOR_W +: COLOR_W]    // Blue
  };

  // Outside DE the output is black at either range level
  a_blank_outside_de: assert property (
    @(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    !DE_o |-> (VD_o == '0) || (VD_o == {3{BLACK_LIM}})
  );

endmodule

//--- ppu_out_top.sv
// Config and PAL flag must be synchronous to VCLK_Tx; no back-pressure, stream moves every cycle
`timescale 1ns/1ps

module ppu_out_top
  import ppu_pkg::*;
#(
  parameter int COLOR_W = 8
) (
  input  logic                 VCLK_Tx,
  input  logic                 nVRST_Tx,
  input  ppu_cfg_t             cfg_i,
  input  logic                 palmode_i,
  input  vid_sync_t            sync_i,
  input  logic [3*COLOR_W-1:0] VD_i,            // Red on top
  output vmode_t               videomode_o,
  output logic [1:0]           sl_thickness_o,
  output logic                 VSYNC_o,
  output logic                 HSYNC_o,
  output logic                 DE_o,
  output logic [3*COLOR_W-1:0] VD_o
);

  logic                 limited_en_w;   // Registered range select
  logic [3*COLOR_W-1:0] lane_color_w;   // Lane i in slice i, red first

  // ====================================================================
  // Mode resolution
  // ====================================================================

  vmode_resolver vmode_resolver_u (
    .VCLK_Tx        (VCLK_Tx),
    .nVRST_Tx       (nVRST_Tx),
    .cfg_i          (cfg_i),
    .palmode_i      (palmode_i),
    .videomode_o    (videomode_o),
    .sl_thickness_o (sl_thickness_o),
    .limited_en_o   (limited_en_w)
  );

  // ====================================================================
  // Colour lanes and output
  // ====================================================================

  generate
    for (genvar i = 0; i < 3; i++) begin : g_lane
      rgb_range_lane #(
        .COLOR_W (COLOR_W)
      ) rgb_range_lane_u (
        .VCLK_Tx      (VCLK_Tx),
        .nVRST_Tx     (nVRST_Tx),
        .limited_en_i (limited_en_w),
        .color_i      (VD_i[(2-i)*COLOR_W +: COLOR_W]),  // 0 red, 1 green, 2 blue
        .color_o      (lane_color_w[i*COLOR_W +: COLOR_W])
      );
    end
  endgenerate

  video_out_stage #(
    .COLOR_W (COLOR_W)
  ) video_out_stage_u (
    .VCLK_Tx      (VCLK_Tx),
    .nVRST_Tx     (nVRST_Tx),
    .sync_i       (sync_i),
    .lane_color_i (lane_color_w),
    .VSYNC_o      (VSYNC_o),
    .HSYNC_o      (HSYNC_o),
    .DE_o         (DE_o),
    .VD_o         (VD_o)
  );

endmodule

//--- tb_vectors.svh
// Included inside tb_ppu_out after the ppu_pkg import; mode rows expect limited_rgb clear
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

  // ====================================================================
  // Mode table, target and flags in, resolved mode out
  // ====================================================================

  typedef struct packed {
    target_res_t tgt;
    logic        vga;
    logic        f50;
    logic        f60;
    logic        llm;
    logic        pal;
    vmode_t      exp_mode;
  } mode_vec_t;

  localparam int N_MODE_VEC = 14;

  //  tgt        vga   f50   f60   llm   pal   expected
  localparam mode_vec_t MODE_VECS [N_MODE_VEC] = '{
    '{TGT_480P,  1'b0, 1'b0, 1'b0, 1'b0, 1'b0, VM_480P60},
    '{TGT_480P,  1'b1, 1'b0, 1'b0, 1'b0, 1'b0, VM_VGA60},
    '{TGT_480P,  1'b1, 1'b0, 1'b0, 1'b0, 1'b1, VM_576P50},   // PAL beats VGA
    '{TGT_720P,  1'b0, 1'b0, 1'b0, 1'b0, 1'b0, VM_720P60},
    '{TGT_720P,  1'b0, 1'b0, 1'b0, 1'b0, 1'b1, VM_720P50},
    '{TGT_960P,  1'b0, 1'b1, 1'b0, 1'b0, 1'b0, VM_960P50},   // Forced 50
    '{TGT_1080P, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, VM_1080P60},  // Forced 60 over PAL
    '{TGT_1080P, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, VM_1080P60},  // force60 has priority
    '{TGT_1200P, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, VM_1200P50},  // LLM veto, PAL wins
    '{TGT_1200P, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, VM_1200P60},  // LLM veto, NTSC wins
    '{TGT_480P,  1'b1, 1'b1, 1'b0, 1'b0, 1'b0, VM_576P50},
    '{TGT_480P,  1'b1, 1'b0, 1'b1, 1'b1, 1'b0, VM_VGA60},
    '{TGT_960P,  1'b0, 1'b0, 1'b0, 1'b1, 1'b0, VM_960P60},
    '{TGT_1200P, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, VM_1200P60}
  };

  // Thickness thresholds at 6 and 14
  typedef struct packed {
    logic [4:0] vscale;
    logic [1:0] exp_thick;
  } thick_vec_t;

  localparam int N_THICK_VEC = 5;

  localparam thick_vec_t THICK_VECS [N_THICK_VEC] = '{
    '{5'd5,  2'd0},
    '{5'd6,  2'd1},
    '{5'd13, 2'd1},
    '{5'd14, 2'd2},
    '{5'd31, 2'd2}
  };

`endif

//--- tb_ppu_out.sv
// Runs at COLOR_W 8 only; inputs change 1 ns after the rising edge, outputs sampled just before
`timescale 1ns/1ps

module tb_ppu_out
  import ppu_pkg::*;
;

  localparam int CW          = 8;
  localparam int CLK_PERIOD  = 8;
  localparam int RESET_CYC   = 8;
  localparam int N_PIX       = 64;   // Random pixels per stream test
  localparam int N_EXPL      = 3;

  `include "tb_vectors.svh"

  // Explicit limited range corners, input and expected output per row
  typedef struct packed {
    logic [3*CW-1:0] px_in;
    logic [3*CW-1:0] px_out;
  } expl_t;

  localparam expl_t EXPL [N_EXPL] = '{
    '{24'h000000, 24'h101010},   // Black to 16
    '{24'hFFFFFF, 24'hEBEBEB},   // White to 235
    '{24'hFF0080, 24'hEB107E}    // Mixed channels
  };

  // Stream length plus table rows plus settling margin
  localparam int TIMEOUT_CYC = RESET_CYC + 2 + N_MODE_VEC + N_THICK_VEC
                               + 2 * (N_PIX + N_EXPL + 8) + 40;

  logic            VCLK_Tx = 1'b0;
  logic            nVRST_Tx;
  ppu_cfg_t        cfg_i;
  logic            palmode_i;
  vid_sync_t       sync_i;
  logic [3*CW-1:0] VD_i;
  vmode_t          videomode_o;
  logic [1:0]      sl_thickness_o;
  logic            VSYNC_o;
  logic            HSYNC_o;
  logic            DE_o;
  logic [3*CW-1:0] VD_o;

  logic [31:0] lfsr_q;
  string       test_name;
  int          test_err;
  int          err_cnt;
  int          n_tests;
  int          n_failed;

  always #(CLK_PERIOD / 2) VCLK_Tx = ~VCLK_Tx;

  ppu_out_top #(
    .COLOR_W (CW)
  ) uut (
    .VCLK_Tx        (VCLK_Tx),
    .nVRST_Tx       (nVRST_Tx),
    .cfg_i          (cfg_i),
    .palmode_i      (palmode_i),
    .sync_i         (sync_i),
    .VD_i           (VD_i),
    .videomode_o    (videomode_o),
    .sl_thickness_o (sl_thickness_o),
    .VSYNC_o        (VSYNC_o),
    .HSYNC_o        (HSYNC_o),
    .DE_o           (DE_o),
    .VD_o           (VD_o)
  );

  // ====================================================================
  // Helpers
  // ====================================================================

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val = {val[30:0], lfsr_q[0]};   // One step per bit
    end
  endtask

  // q = v * 220 / 2^(CW-1), then half with round up, then black level
  function automatic logic [CW-1:0] limited_of(input logic [CW-1:0] v);
    int q;
    q = (int'(v) * 220) >>> (CW - 1);
    return CW'(q / 2 + q % 2 + (16 << (CW - 8)));
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
      test_err++;
      err_cnt++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_err  = 0;
  endtask

  task automatic end_test();
    n_tests++;
    if (test_err != 0)
      n_failed++;
    $display("%-12s %s, %0d errors", test_name, (test_err != 0) ? "failed" : "passed", test_err);
  endtask

  task automatic check_reset_outputs();
    check_val("VSYNC_o", 32'(VSYNC_o), 32'd0);
    check_val("HSYNC_o", 32'(HSYNC_o), 32'd0);
    check_val("DE_o", 32'(DE_o), 32'd0);
    check_val("VD_o", 32'(VD_o), 32'd0);
    check_val("videomode_o", 32'(videomode_o), 32'(VM_480P60));
    check_val("sl_thickness_o", 32'(sl_thickness_o), 32'd0);
  endtask

  // Pixel i driven at iteration i shows on the ports at iteration i+3
  task automatic run_stream(input logic limited);
    logic [3+3*CW-1:0] exp_q [$];
    logic [3+3*CW-1:0] exp_w;
    logic [31:0]       bits;
    vid_sync_t         s;
    logic [3*CW-1:0]   px;
    logic [3*CW-1:0]   vd_exp;
    int                n_all;
    n_all = limited ? N_PIX + N_EXPL : N_PIX;
    for (int i = 0; i < n_all + 3; i++) begin
      @(posedge VCLK_Tx);
      #1;
      if (i >= 3) begin
        exp_w = exp_q.pop_front();
        check_val("VSYNC_o", 32'(VSYNC_o), 32'(exp_w[3*CW+2]));
        check_val("HSYNC_o", 32'(HSYNC_o), 32'(exp_w[3*CW+1]));
        check_val("DE_o", 32'(DE_o), 32'(exp_w[3*CW]));
        check_val("VD_o", 32'(VD_o), 32'(exp_w[3*CW-1:0]));
      end
      if (i < n_all) begin
        if (limited && i < N_EXPL) begin
          s      = '{vsync: 1'b0, hsync: 1'b0, de: 1'b1};
          px     = EXPL[i].px_in;
          vd_exp = EXPL[i].px_out;
        end else begin
          take_bits(3, bits);
          s = vid_sync_t'(bits[2:0]);
          px = '0;                      // Source blanks outside DE
          if (s.de) begin
            take_bits(3 * CW, bits);
            px = bits[3*CW-1:0];
          end
          if (limited)
            vd_exp = {limited_of(px[3*CW-1:2*CW]), limited_of(px[2*CW-1:CW]),
                      limited_of(px[CW-1:0])};
          else
            vd_exp = px;
        end
        sync_i = s;
        VD_i   = px;
        exp_q.push_back({s, vd_exp});
      end else begin
        sync_i = '0;
        VD_i   = '0;
      end
    end
  endtask

  // Hold the config until the range select reaches the last lane stage
  task automatic set_range(input logic limited);
    cfg_i.limited_rgb = limited;
    repeat (4) @(posedge VCLK_Tx);
    #1;
  endtask

  // ====================================================================
  // Test sequence
  // ====================================================================

  initial begin
    nVRST_Tx  = 1'b0;
    cfg_i     = '{target_res: TGT_1080P, use_vga_480p: 1'b1, force50: 1'b1, force60: 1'b0,
                  llm: 1'b0, limited_rgb: 1'b1, vscale: 5'd20};  // Busy inputs under reset
    palmode_i = 1'b1;
    sync_i    = '1;
    VD_i      = '1;
    lfsr_q    = 32'h95e;
    err_cnt   = 0;
    n_tests   = 0;
    n_failed  = 0;

    begin_test("reset");
    repeat (RESET_CYC) begin
      @(posedge VCLK_Tx);
      #1;
      check_reset_outputs();
    end
    nVRST_Tx  = 1'b1;
    cfg_i     = '0;     // 480p, 60 Hz, full range
    palmode_i = 1'b0;
    sync_i    = '0;
    VD_i      = '0;
    check_reset_outputs();
    @(posedge VCLK_Tx);
    #1;
    check_reset_outputs();
    end_test();

    begin_test("mode table");
    for (int k = 0; k < N_MODE_VEC; k++) begin
      cfg_i.target_res   = MODE_VECS[k].tgt;
      cfg_i.use_vga_480p = MODE_VECS[k].vga;
      cfg_i.force50      = MODE_VECS[k].f50;
      cfg_i.force60      = MODE_VECS[k].f60;
      cfg_i.llm          = MODE_VECS[k].llm;
      palmode_i          = MODE_VECS[k].pal;
      @(posedge VCLK_Tx);
      #1;
      check_val("videomode_o", 32'(videomode_o), 32'(MODE_VECS[k].exp_mode));
    end
    end_test();

    begin_test("thickness");
    for (int k = 0; k < N_THICK_VEC; k++) begin
      cfg_i.vscale = THICK_VECS[k].vscale;
      @(posedge VCLK_Tx);
      #1;
      check_val("sl_thickness_o", 32'(sl_thickness_o), 32'(THICK_VECS[k].exp_thick));
    end
    end_test();

    begin_test("full range");
    set_range(1'b0);
    run_stream(1'b0);
    end_test();

    begin_test("limited");
    set_range(1'b1);
    run_stream(1'b1);
    end_test();

    $display("Tests %0d, failed %0d, mismatches %0d", n_tests, n_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_CYC * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the test sequence did not finish", TIMEOUT_CYC);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- flist.f
+incdir+.
ppu_pkg.sv
vmode_resolver.sv
rgb_range_lane.sv
video_out_stage.sv
ppu_out_top.sv
tb_ppu_out.sv

//--- Makefile
# Verilator build for the post-processing output chain
TOP = tb_ppu_out

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -Wno-fatal --timing -f flist.f --top-module $(TOP)

sim:
	verilator --binary --assert -Wno-fatal -f flist.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
